/* Bender.yml */
package:
  name: glb

sources:
  - src/glb_param_pkg.sv
  - src/glb_packet_pkg.sv
  - src/glb_mem_if.sv
  - src/glb_bank_memory.sv
  - src/glb_bank_ctrl.sv
  - src/glb_bank.sv
  - src/glb_bank_router.sv
  - src/glb_top.sv
  - target: simulation
    files:
      - bench/glb_clk_gen.sv
      - bench/glb_assert.sv
      - bench/glb_tb.sv

/* bench/glb_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_assert (
    input logic clk,
    input logic rst,
    input logic rd_en,
    input logic rd_data_valid
);

import glb_param_pkg::*;

// number of failed assertions
int fail_count = 0;

// response register is cleared by reset
a_valid_low_after_reset: assert property (
    @(posedge clk) rst |=> !rd_data_valid
) else begin
    $error("rd_data_valid high in the cycle after reset");
    fail_count++;
end

// each returned word goes back to a read sampled three edges earlier
a_valid_has_read: assert property (
    @(posedge clk) disable iff (rst)
    rd_data_valid |-> $past(rd_en, GLB_RD_LATENCY)
) else begin
    $error("rd_data_valid without a matching rd_en");
    fail_count++;
end

// no unknown valid once out of reset
a_valid_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(rd_data_valid)
) else begin
    $error("rd_data_valid is unknown");
    fail_count++;
end

endmodule

bind glb_top glb_assert u_glb_assert (
    .clk           (clk),
    .rst           (rst),
    .rd_en         (rd_en),
    .rd_data_valid (rd_data_valid)
);

`default_nettype wire

/* bench/glb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_clk_gen (
    output logic clk,
    output logic rst
);

// 100 ns clock period
localparam int HALF_PERIOD  = 50;
// reset held over this many rising edges
localparam int RESET_CYCLES = 2;

initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
end

initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
end

endmodule

`default_nettype wire

/* bench/glb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_tb;

import glb_param_pkg::*;

localparam int CLK_PERIOD   = 100;
localparam int DRAIN_CYCLES = GLB_RD_LATENCY + 4;
// cycle budget of the tests in the order they run
localparam int TEST_CYCLES  = 8 + 8 * 12 + (8 * 3 + 12) + (16 + 12) + 4 * 18 + (6 * 4 + 12);
localparam int MARGIN_CYCLES = 100;

logic                       clk;
logic                       rst;
logic                       wr_en;
logic [BANK_STRB_WIDTH-1:0] wr_strb;
logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
logic [BANK_DATA_WIDTH-1:0] wr_data;
logic                       rd_en;
logic [GLB_ADDR_WIDTH-1:0]  rd_addr;
logic [BANK_DATA_WIDTH-1:0] rd_data;
logic                       rd_data_valid;
// high when the read driven this cycle is expected to return
logic                       rd_live;

// byte-wise reference memory
logic [7:0]                 sb_mem [2**GLB_ADDR_WIDTH];
logic [BANK_DATA_WIDTH-1:0] exp_q [$];
logic [GLB_RD_LATENCY-1:0]  live_hist;
logic [63:0]                rng_state;
int                         errors;
int                         reads_done;

glb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
);

glb_top dut (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_strb       (wr_strb),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
);

task automatic check(input string name, input logic [63:0] actual, input logic [63:0] expected);
    if (actual !== expected) begin
        $display("Fail time=%0t %s got %h expected %h", $time, name, actual, expected);
        errors++;
    end
endtask

// xorshift64 step
function automatic logic [63:0] rand64();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
endfunction

// word aligned byte address of a word in a bank
function automatic logic [GLB_ADDR_WIDTH-1:0] word_addr(input int bank, input int word);
    return GLB_ADDR_WIDTH'((bank * BANK_WORDS + word) * BANK_STRB_WIDTH);
endfunction

function automatic logic [63:0] sb_read(input logic [GLB_ADDR_WIDTH-1:0] addr);
    logic [63:0] w;
    for (int i = 0; i < BANK_STRB_WIDTH; i++) begin
        w[i*8 +: 8] = sb_mem[{addr[GLB_ADDR_WIDTH-1:BANK_BYTE_OFFSET], BANK_BYTE_OFFSET'(i)}];
    end
    return w;
endfunction

// one cycle of stimulus and the matching reference model update
task automatic drive(input logic we, input logic [7:0] strb, input logic [11:0] waddr,
                     input logic [63:0] wdata, input logic re, input logic [11:0] raddr);
    logic live;
    // the write wins a same-bank pair and the read is lost
    live = re && !(we && waddr[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH]
                         == raddr[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH]);
    @(posedge clk);
    wr_en   <= we;
    wr_strb <= strb;
    wr_addr <= waddr;
    wr_data <= wdata;
    rd_en   <= re;
    rd_addr <= raddr;
    rd_live <= live;
    for (int i = 0; i < BANK_STRB_WIDTH; i++) begin
        if (we && strb[i]) begin
            sb_mem[{waddr[GLB_ADDR_WIDTH-1:BANK_BYTE_OFFSET], BANK_BYTE_OFFSET'(i)}]
                = wdata[i*8 +: 8];
        end
    end
    if (live) begin
        exp_q.push_back(sb_read(raddr));
    end
endtask

task automatic write_word(input logic [11:0] addr, input logic [7:0] strb, input logic [63:0] data);
    drive(1'b1, strb, addr, data, 1'b0, '0);
endtask

task automatic read_word(input logic [11:0] addr);
    drive(1'b0, '0, '0, '0, 1'b1, addr);
endtask

task automatic idle();
    drive(1'b0, '0, '0, '0, 1'b0, '0);
endtask

// bounded wait until every expected read has come back
task automatic wait_drain();
    int n;
    idle();
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
        @(negedge clk);
        n++;
    end
    if (exp_q.size() != 0) begin
        $display("time=%0t %0d reads never returned", $time, exp_q.size());
        errors++;
        exp_q.delete();
    end
endtask

// response monitor sampled mid-cycle
always @(negedge clk) begin
    logic [63:0] exp_data;
    if (rst) begin
        live_hist = '0;
    end else begin
        // valid exactly three cycles after each surviving read
        check("rd_data_valid", rd_data_valid, live_hist[GLB_RD_LATENCY-1]);
        if (rd_data_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("time=%0t read data returned with no read outstanding", $time);
                errors++;
            end else begin
                exp_data = exp_q.pop_front();
                check("rd_data", rd_data, exp_data);
                reads_done++;
            end
        end
        live_hist = {live_hist[GLB_RD_LATENCY-2:0], rd_en & rd_live};
    end
end

task automatic reset_idle();
    @(negedge clk);
    while (rst) begin
        check("rd_data_valid", rd_data_valid, '0);
        @(negedge clk);
    end
    repeat (4) begin
        check("rd_data_valid", rd_data_valid, '0);
        @(negedge clk);
    end
endtask

// one read at a time so each return is seen on its own
task automatic full_writes();
    logic [GLB_ADDR_WIDTH-1:0] a;
    for (int i = 0; i < 8; i++) begin
        a = word_addr(i % NUM_BANKS, int'(rand64() % BANK_WORDS));
        write_word(a, '1, rand64());
        idle();
        read_word(a);
        wait_drain();
    end
endtask

task automatic partial_writes();
    logic [GLB_ADDR_WIDTH-1:0] a;
    for (int i = 0; i < 8; i++) begin
        a = word_addr(i % NUM_BANKS, int'(rand64() % BANK_WORDS));
        // known base then random bytes over it
        write_word(a, '1, rand64());
        write_word(a, BANK_STRB_WIDTH'(rand64()), rand64());
        read_word(a);
    end
    wait_drain();
endtask

task automatic back_to_back_reads();
    logic [GLB_ADDR_WIDTH-1:0] addrs [8];
    for (int i = 0; i < 8; i++) begin
        addrs[i] = word_addr(i % NUM_BANKS, int'(rand64() % BANK_WORDS));
        write_word(addrs[i], '1, rand64());
    end
    // bank changes on every read
    for (int i = 0; i < 8; i++) begin
        read_word(addrs[i]);
    end
    wait_drain();
endtask

task automatic bank_conflicts();
    logic [GLB_ADDR_WIDTH-1:0] a_old;
    logic [GLB_ADDR_WIDTH-1:0] a_new;
    logic [GLB_ADDR_WIDTH-1:0] a_other;
    for (int b = 0; b < NUM_BANKS; b++) begin
        a_old   = word_addr(b, int'(rand64() % BANK_WORDS));
        a_new   = word_addr(b, int'(rand64() % BANK_WORDS));
        a_other = word_addr((b + 1) % NUM_BANKS, int'(rand64() % BANK_WORDS));
        write_word(a_old, '1, rand64());
        // same bank so the read must vanish
        drive(1'b1, '1, a_new, rand64(), 1'b1, a_old);
        read_word(a_new);
        read_word(a_old);
        // different banks so both go through
        drive(1'b1, '1, a_other, rand64(), 1'b1, a_old);
        read_word(a_other);
        wait_drain();
    end
endtask

task automatic read_after_write();
    logic [GLB_ADDR_WIDTH-1:0] a;
    for (int i = 0; i < 6; i++) begin
        a = word_addr(i % NUM_BANKS, int'(rand64() % BANK_WORDS));
        write_word(a, '1, rand64());
        read_word(a);
        write_word(a, BANK_STRB_WIDTH'(rand64()), rand64());
        read_word(a);
    end
    wait_drain();
endtask

// watchdog
initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("STATUS: FAIL");
    $finish;
end

initial begin
    wr_en      = 1'b0;
    wr_strb    = '0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_en      = 1'b0;
    rd_addr    = '0;
    rd_live    = 1'b0;
    live_hist  = '0;
    rng_state  = 64'd67930;
    errors     = 0;
    reads_done = 0;
    reset_idle();
    full_writes();
    partial_writes();
    back_to_back_reads();
    bank_conflicts();
    read_after_write();
    idle();
    $display("errors: %0d, assertion failures: %0d, reads checked: %0d",
             errors, dut.u_glb_assert.fail_count, reads_done);
    if (errors == 0 && dut.u_glb_assert.fail_count == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

/* files.f */
src/glb_param_pkg.sv
src/glb_packet_pkg.sv
src/glb_mem_if.sv
src/glb_bank_memory.sv
src/glb_bank_ctrl.sv
src/glb_bank.sv
src/glb_bank_router.sv
src/glb_top.sv
bench/glb_clk_gen.sv
bench/glb_assert.sv
bench/glb_tb.sv

/* src/glb_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_bank (
    input  logic                         clk,
    input  logic                         rst,

    input  glb_packet_pkg::wr_packet_t   wr_packet,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet
);

import glb_param_pkg::*;

// byte strobe spread over the bits of each byte
logic [BANK_DATA_WIDTH-1:0] wr_bit_sel;

always_comb begin
    for (int i = 0; i < BANK_STRB_WIDTH; i++) begin
        wr_bit_sel[i*8 +: 8] = {8{wr_packet.wr_strb[i]}};
    end
end

// controller to sram link
glb_mem_if mem_if ();

// request registers, conflict handling, read valid
glb_bank_ctrl u_bank_ctrl (
    .clk         (clk),
    .rst         (rst),
    .wr_packet   (wr_packet),
    .wr_bit_sel  (wr_bit_sel),
    .rdrq_packet (rdrq_packet),
    .rdrs_packet (rdrs_packet),
    .mem         (mem_if.ctrl)
);

// single port storage
glb_bank_memory u_bank_memory (
    .clk (clk),
    .mem (mem_if.mem)
);

endmodule

`default_nettype wire

/* src/glb_bank_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_bank_ctrl (
    input  logic                                      clk,
    input  logic                                      rst,

    input  glb_packet_pkg::wr_packet_t                wr_packet,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] wr_bit_sel,
    input  glb_packet_pkg::rdrq_packet_t              rdrq_packet,
    output glb_packet_pkg::rdrs_packet_t              rdrs_packet,

    glb_mem_if.ctrl                                   mem
);

import glb_param_pkg::*;

logic                       rd_accept;
// one bit per cycle of read latency
// bit 0 doubles as the sram read enable
logic [BANK_RD_LATENCY-1:0] rd_pipe;

// write wins a same-bank conflict, the read is dropped
assign rd_accept = rdrq_packet.rd_en & ~wr_packet.wr_en;

// control state
always_ff @(posedge clk) begin
    if (rst) begin
        mem.wen <= 1'b0;
        rd_pipe <= '0;
    end else begin
        mem.wen <= wr_packet.wr_en;
        rd_pipe <= {rd_pipe[BANK_RD_LATENCY-2:0], rd_accept};
    end
end

// request payload
// address follows whichever strobe won
always_ff @(posedge clk) begin
    if (wr_packet.wr_en) begin
        mem.addr            <= wr_packet.wr_addr[BANK_ADDR_WIDTH-1:0];
        mem.data_in         <= wr_packet.wr_data;
        mem.data_in_bit_sel <= wr_bit_sel;
    end else if (rdrq_packet.rd_en) begin
        mem.addr            <= rdrq_packet.rd_addr[BANK_ADDR_WIDTH-1:0];
    end
end

// registered read request goes to the sram
assign mem.ren = rd_pipe[0];

// valid lines up with data_out, one cycle after ren
assign rdrs_packet.rd_data       = mem.data_out;
assign rdrs_packet.rd_data_valid = rd_pipe[BANK_RD_LATENCY-1];

endmodule

`default_nettype wire

/* src/glb_bank_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_bank_memory (
    input  logic    clk,
    glb_mem_if.mem  mem
);

import glb_param_pkg::*;

localparam int WORD_IDX_WIDTH = BANK_ADDR_WIDTH - BANK_BYTE_OFFSET;

// storage, contents come up undefined
logic [BANK_DATA_WIDTH-1:0] mem_array [BANK_WORDS];
logic [WORD_IDX_WIDTH-1:0]  word_idx;

// drop the byte offset, the array is word addressed
assign word_idx = mem.addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];

// masked write
// bits outside the mask keep their old value
always_ff @(posedge clk) begin
    if (mem.wen) begin
        mem_array[word_idx] <= (mem_array[word_idx] & ~mem.data_in_bit_sel)
                             | (mem.data_in & mem.data_in_bit_sel);
    end
end

// synchronous read
// data_out holds the last word read until the next ren
always_ff @(posedge clk) begin
    if (mem.ren) begin
        mem.data_out <= mem_array[word_idx];
    end
end

endmodule

`default_nettype wire

/* src/glb_bank_router.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_bank_router (
    input  logic                         clk,
    input  logic                         rst,

    input  glb_packet_pkg::wr_packet_t   wr_packet,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet,

    output glb_packet_pkg::wr_packet_t   bank_wr_packet   [glb_param_pkg::NUM_BANKS],
    output glb_packet_pkg::rdrq_packet_t bank_rdrq_packet [glb_param_pkg::NUM_BANKS],
    input  glb_packet_pkg::rdrs_packet_t bank_rdrs_packet [glb_param_pkg::NUM_BANKS],

    output glb_packet_pkg::rdrs_packet_t rdrs_packet
);

import glb_param_pkg::*;

logic [BANK_SEL_WIDTH-1:0]  wr_bank_sel;
logic [BANK_SEL_WIDTH-1:0]  rd_bank_sel;
logic [BANK_DATA_WIDTH-1:0] merged_data;
logic                       merged_valid;

// bank select is the top of the byte address
assign wr_bank_sel = wr_packet.wr_addr[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
assign rd_bank_sel = rdrq_packet.rd_addr[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH];

// every bank sees the payload
// only the selected one sees its enable high
always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
        bank_wr_packet[b]         = wr_packet;
        bank_wr_packet[b].wr_en   = wr_packet.wr_en
                                  && (wr_bank_sel == BANK_SEL_WIDTH'(b));
        bank_rdrq_packet[b]       = rdrq_packet;
        bank_rdrq_packet[b].rd_en = rdrq_packet.rd_en
                                  && (rd_bank_sel == BANK_SEL_WIDTH'(b));
    end
end

// fixed bank latency and one read per cycle
// so at most one bank is valid here
always_comb begin
    merged_data  = '0;
    merged_valid = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
        // idle banks still hold stale data_out, mask it off
        merged_data  = merged_data
                     | (bank_rdrs_packet[b].rd_data
                        & {BANK_DATA_WIDTH{bank_rdrs_packet[b].rd_data_valid}});
        merged_valid = merged_valid | bank_rdrs_packet[b].rd_data_valid;
    end
end

// response register, adds the third cycle of read latency
always_ff @(posedge clk) begin
    if (rst) begin
        rdrs_packet.rd_data_valid <= 1'b0;
    end else begin
        rdrs_packet.rd_data_valid <= merged_valid;
    end
end

always_ff @(posedge clk) begin
    rdrs_packet.rd_data <= merged_data;
end

endmodule

`default_nettype wire

/* src/glb_mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface glb_mem_if;

import glb_param_pkg::*;

// one access per cycle, never ren and wen together
logic                       ren;
logic                       wen;
logic [BANK_ADDR_WIDTH-1:0] addr;
logic [BANK_DATA_WIDTH-1:0] data_in;
// per-bit write mask
logic [BANK_DATA_WIDTH-1:0] data_in_bit_sel;
logic [BANK_DATA_WIDTH-1:0] data_out;

// controller side
modport ctrl (
    output ren, wen, addr, data_in, data_in_bit_sel,
    input  data_out
);

// sram side
modport mem (
    input  ren, wen, addr, data_in, data_in_bit_sel,
    output data_out
);

endinterface

`default_nettype wire

/* src/glb_packet_pkg.sv */
`default_nettype none

package glb_packet_pkg;

import glb_param_pkg::*;

// write request, strobe is one bit per byte of wr_data
typedef struct packed {
    logic                       wr_en;
    logic [BANK_STRB_WIDTH-1:0] wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
    logic [BANK_DATA_WIDTH-1:0] wr_data;
} wr_packet_t;

// read request
typedef struct packed {
    logic                      rd_en;
    logic [GLB_ADDR_WIDTH-1:0] rd_addr;
} rdrq_packet_t;

// read response, data only meaningful while valid is high
typedef struct packed {
    logic [BANK_DATA_WIDTH-1:0] rd_data;
    logic                       rd_data_valid;
} rdrs_packet_t;

endpackage

`default_nettype wire

/* src/glb_param_pkg.sv */
`default_nettype none

package glb_param_pkg;

// bank organisation
localparam int NUM_BANKS        = 4;
localparam int BANK_SEL_WIDTH   = $clog2(NUM_BANKS);

// one word is 64 bits wide with a byte strobe per byte
localparam int BANK_DATA_WIDTH  = 64;
localparam int BANK_STRB_WIDTH  = BANK_DATA_WIDTH / 8;
localparam int BANK_BYTE_OFFSET = $clog2(BANK_STRB_WIDTH);

// byte address inside one bank, 1 KiB per bank
localparam int BANK_ADDR_WIDTH  = 10;
localparam int BANK_WORDS       = 2 ** (BANK_ADDR_WIDTH - BANK_BYTE_OFFSET);

// full byte address, bank select sits in the top bits
localparam int GLB_ADDR_WIDTH   = BANK_ADDR_WIDTH + BANK_SEL_WIDTH;

// request register plus synchronous sram read
localparam int BANK_RD_LATENCY  = 2;
// router adds one register on the response path
localparam int GLB_RD_LATENCY   = BANK_RD_LATENCY + 1;

endpackage

`default_nettype wire

/* src/glb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module glb_top (
    input  logic                                      clk,
    input  logic                                      rst,

    // write port
    input  logic                                      wr_en,
    input  logic [glb_param_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] wr_data,

    // read port
    input  logic                                      rd_en,
    input  logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]  rd_addr,
    output logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic                                      rd_data_valid
);

import glb_param_pkg::*;
import glb_packet_pkg::*;

wr_packet_t   wr_packet;
rdrq_packet_t rdrq_packet;
rdrs_packet_t rdrs_packet;

wr_packet_t   bank_wr_packet   [NUM_BANKS];
rdrq_packet_t bank_rdrq_packet [NUM_BANKS];
rdrs_packet_t bank_rdrs_packet [NUM_BANKS];

// pack plain ports
assign wr_packet   = '{wr_en: wr_en, wr_strb: wr_strb, wr_addr: wr_addr, wr_data: wr_data};
assign rdrq_packet = '{rd_en: rd_en, rd_addr: rd_addr};

// unpack the merged response
assign rd_data       = rdrs_packet.rd_data;
assign rd_data_valid = rdrs_packet.rd_data_valid;

// steers requests, merges responses
glb_bank_router u_bank_router (
    .clk              (clk),
    .rst              (rst),
    .wr_packet        (wr_packet),
    .rdrq_packet      (rdrq_packet),
    .bank_wr_packet   (bank_wr_packet),
    .bank_rdrq_packet (bank_rdrq_packet),
    .bank_rdrs_packet (bank_rdrs_packet),
    .rdrs_packet      (rdrs_packet)
);

// one bank per select value
for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    glb_bank u_bank (
        .clk         (clk),
        .rst         (rst),
        .wr_packet   (bank_wr_packet[b]),
        .rdrq_packet (bank_rdrq_packet[b]),
        .rdrs_packet (bank_rdrs_packet[b])
    );
end

endmodule

`default_nettype wire
